// File: mem_pkg.sv
package mem_pkg;

	localparam int WORD_W = 16;
	localparam int ADDR_W = 16;
	localparam int MEM_DEPTH = 256;
	localparam int MEM_AW = $clog2(MEM_DEPTH);
	localparam int LINES = 8;
	localparam int LINE_WORDS = 4;
	localparam int INDEX_W = $clog2(LINES);
	localparam int OFFSET_W = $clog2(LINE_WORDS);
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	// word 0 sits in the low bits
	typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITEBACK,
		ST_REFILL,
		ST_RESPOND
	} cache_state_e;

	function automatic logic [TAG_W-1:0] addr_tag(input addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic logic [INDEX_W-1:0] addr_index(input addr_t a);
		return a[OFFSET_W +: INDEX_W];
	endfunction

	function automatic logic [OFFSET_W-1:0] addr_offset(input addr_t a);
		return a[OFFSET_W-1:0];
	endfunction

	// first word address of a line
	function automatic addr_t line_addr(input logic [TAG_W-1:0] tag,
			input logic [INDEX_W-1:0] index);
		return {tag, index, {OFFSET_W{1'b0}}};
	endfunction

	function automatic word_t get_word(input line_t l, input logic [OFFSET_W-1:0] off);
		return l[off*WORD_W +: WORD_W];
	endfunction

	function automatic line_t put_word(input line_t l, input logic [OFFSET_W-1:0] off,
			input word_t w);
		line_t r;
		r = l;
		r[off*WORD_W +: WORD_W] = w;
		return r;
	endfunction

endpackage

// File: icache.sv
module icache (
	input  logic           clk,
	input  logic           reset_n,
	input  logic           i_fetch,
	input  mem_pkg::addr_t i_fetch_addr,
	output logic           o_fetch_valid,
	output mem_pkg::word_t o_fetch_data,
	output logic           o_mem_read,
	output mem_pkg::addr_t o_mem_addr,
	input  logic           i_mem_valid,
	input  mem_pkg::line_t i_mem_rline
);
	import mem_pkg::*;

	cache_state_e state;
	logic [TAG_W-1:0] tag_q [LINES];
	logic [LINES-1:0] valid_q;
	line_t data_q [LINES];
	addr_t req_addr;
	logic [INDEX_W-1:0] idx;
	logic [INDEX_W-1:0] req_idx;
	logic hit;

	assign idx = addr_index(i_fetch_addr);
	assign req_idx = addr_index(req_addr);
	assign hit = valid_q[idx] && (tag_q[idx] == addr_tag(i_fetch_addr));
	assign o_mem_addr = line_addr(addr_tag(req_addr), req_idx);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ST_IDLE;
			valid_q <= '0;
			o_fetch_valid <= 1'b0;
			o_mem_read <= 1'b0;
		end else begin
			o_fetch_valid <= 1'b0;
			o_mem_read <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_fetch) begin
						if (hit) begin
							o_fetch_valid <= 1'b1;
						end else begin
							o_mem_read <= 1'b1;
							state <= ST_REFILL;
						end
					end
				end
				ST_REFILL: begin
					// answer straight from the returned line
					if (i_mem_valid) begin
						valid_q[req_idx] <= 1'b1;
						o_fetch_valid <= 1'b1;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && i_fetch) begin
			req_addr <= i_fetch_addr;
			o_fetch_data <= get_word(data_q[idx], addr_offset(i_fetch_addr));
		end
		if (state == ST_REFILL && i_mem_valid) begin
			tag_q[req_idx] <= addr_tag(req_addr);
			data_q[req_idx] <= i_mem_rline;
			o_fetch_data <= get_word(i_mem_rline, addr_offset(req_addr));
		end
	end

endmodule

// File: dcache.sv
module dcache (
	input  logic           clk,
	input  logic           reset_n,
	input  logic           i_d_read,
	input  logic           i_d_write,
	input  mem_pkg::addr_t i_d_addr,
	input  mem_pkg::word_t i_d_wdata,
	output logic           o_d_valid,
	output mem_pkg::word_t o_d_rdata,
	output logic           o_mem_read,
	output logic           o_mem_write,
	output mem_pkg::addr_t o_mem_addr,
	output mem_pkg::line_t o_mem_wline,
	input  logic           i_mem_valid,
	input  mem_pkg::line_t i_mem_rline
);
	import mem_pkg::*;

	cache_state_e state;
	logic [TAG_W-1:0] tag_q [LINES];
	logic [LINES-1:0] valid_q;
	logic [LINES-1:0] dirty_q;
	line_t data_q [LINES];
	addr_t req_addr;
	word_t req_wdata;
	logic req_write;
	logic [INDEX_W-1:0] idx;
	logic [INDEX_W-1:0] req_idx;
	logic [OFFSET_W-1:0] req_off;
	logic access;
	logic hit;
	line_t fill_line;

	assign access = i_d_read || i_d_write;
	assign idx = addr_index(i_d_addr);
	assign req_idx = addr_index(req_addr);
	assign req_off = addr_offset(req_addr);
	assign hit = valid_q[idx] && (tag_q[idx] == addr_tag(i_d_addr));

	// pending write is merged into the incoming line
	assign fill_line = req_write ? put_word(i_mem_rline, req_off, req_wdata) : i_mem_rline;

	// victim address comes from the stored tag while writing back
	assign o_mem_addr = (state == ST_WRITEBACK) ? line_addr(tag_q[req_idx], req_idx)
		: line_addr(addr_tag(req_addr), req_idx);
	assign o_mem_wline = data_q[req_idx];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ST_IDLE;
			valid_q <= '0;
			dirty_q <= '0;
			o_d_valid <= 1'b0;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
		end else begin
			o_d_valid <= 1'b0;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (access) begin
						if (hit) begin
							o_d_valid <= 1'b1;
							if (i_d_write)
								dirty_q[idx] <= 1'b1;
						end else if (valid_q[idx] && dirty_q[idx]) begin
							o_mem_write <= 1'b1;
							state <= ST_WRITEBACK;
						end else begin
							o_mem_read <= 1'b1;
							state <= ST_REFILL;
						end
					end
				end
				ST_WRITEBACK: begin
					if (i_mem_valid) begin
						o_mem_read <= 1'b1;
						state <= ST_REFILL;
					end
				end
				ST_REFILL: begin
					if (i_mem_valid) begin
						valid_q[req_idx] <= 1'b1;
						dirty_q[req_idx] <= req_write;
						state <= ST_RESPOND;
					end
				end
				ST_RESPOND: begin
					o_d_valid <= 1'b1;
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && access) begin
			req_addr <= i_d_addr;
			req_wdata <= i_d_wdata;
			req_write <= i_d_write;
			if (i_d_write)
				o_d_rdata <= i_d_wdata;
			else
				o_d_rdata <= get_word(data_q[idx], addr_offset(i_d_addr));
			if (hit && i_d_write)
				data_q[idx] <= put_word(data_q[idx], addr_offset(i_d_addr), i_d_wdata);
		end
		if (state == ST_REFILL && i_mem_valid) begin
			tag_q[req_idx] <= addr_tag(req_addr);
			data_q[req_idx] <= fill_line;
		end
		if (state == ST_RESPOND)
			o_d_rdata <= get_word(data_q[req_idx], req_off);
	end

endmodule

// File: main_memory.sv
module main_memory #(
	parameter int MEM_LATENCY = 6
) (
	input  logic           clk,
	input  logic           reset_n,
	input  logic           i_i_read,
	input  mem_pkg::addr_t i_i_addr,
	output logic           o_i_valid,
	output mem_pkg::line_t o_i_rline,
	input  logic           i_d_read,
	input  logic           i_d_write,
	input  mem_pkg::addr_t i_d_addr,
	input  mem_pkg::line_t i_d_wline,
	output logic           o_d_valid,
	output mem_pkg::line_t o_d_rline
);
	import mem_pkg::*;

	localparam int CNT_W = $clog2(MEM_LATENCY + 1);
	localparam int LN_W = MEM_AW - OFFSET_W;

	word_t mem [MEM_DEPTH];
	logic [CNT_W-1:0] i_cnt;
	logic [CNT_W-1:0] d_cnt;
	logic [LN_W-1:0] i_line_q;
	logic [LN_W-1:0] d_line_q;
	logic d_write_q;

	function automatic line_t read_line(input logic [LN_W-1:0] ln);
		line_t l;
		for (int w = 0; w < LINE_WORDS; w++) begin
			l[w*WORD_W +: WORD_W] = mem[{ln, OFFSET_W'(w)}];
		end
		return l;
	endfunction

	// words past the image stay zero
	initial begin
		for (int k = 0; k < MEM_DEPTH; k++) begin
			mem[k] = '0;
		end
		$readmemh("mem_image.hex", mem);
	end

	// valid lands on the cycle the count reaches one
	assign o_i_valid = (i_cnt == CNT_W'(1));
	assign o_d_valid = (d_cnt == CNT_W'(1));
	assign o_i_rline = read_line(i_line_q);
	assign o_d_rline = read_line(d_line_q);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			i_cnt <= '0;
			d_cnt <= '0;
		end else begin
			if (i_i_read)
				i_cnt <= CNT_W'(MEM_LATENCY);
			else if (i_cnt != '0)
				i_cnt <= i_cnt - CNT_W'(1);
			if (i_d_read || i_d_write)
				d_cnt <= CNT_W'(MEM_LATENCY);
			else if (d_cnt != '0)
				d_cnt <= d_cnt - CNT_W'(1);
		end
	end

	always @(posedge clk) begin
		if (i_i_read)
			i_line_q <= i_i_addr[MEM_AW-1:OFFSET_W];
		if (i_d_read || i_d_write) begin
			d_line_q <= i_d_addr[MEM_AW-1:OFFSET_W];
			d_write_q <= i_d_write;
		end
		if (o_d_valid && d_write_q) begin
			for (int w = 0; w < LINE_WORDS; w++) begin
				mem[{d_line_q, OFFSET_W'(w)}] <= get_word(i_d_wline, OFFSET_W'(w));
			end
		end
	end

endmodule

// File: mem_system.sv
module mem_system #(
	parameter int MEM_LATENCY = 6
) (
	input  logic           clk,
	input  logic           reset_n,
	input  logic           i_fetch,
	input  mem_pkg::addr_t i_fetch_addr,
	output logic           o_fetch_valid,
	output mem_pkg::word_t o_fetch_data,
	input  logic           i_d_read,
	input  logic           i_d_write,
	input  mem_pkg::addr_t i_d_addr,
	input  mem_pkg::word_t i_d_wdata,
	output logic           o_d_valid,
	output mem_pkg::word_t o_d_rdata
);
	import mem_pkg::*;

	// instruction side memory port
	logic im_read;
	addr_t im_addr;
	logic im_valid;
	line_t im_rline;

	// data side memory port
	logic dm_read;
	logic dm_write;
	addr_t dm_addr;
	line_t dm_wline;
	logic dm_valid;
	line_t dm_rline;

	icache u_icache (
		.clk           (clk),
		.reset_n       (reset_n),
		.i_fetch       (i_fetch),
		.i_fetch_addr  (i_fetch_addr),
		.o_fetch_valid (o_fetch_valid),
		.o_fetch_data  (o_fetch_data),
		.o_mem_read    (im_read),
		.o_mem_addr    (im_addr),
		.i_mem_valid   (im_valid),
		.i_mem_rline   (im_rline)
	);

	dcache u_dcache (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_d_read    (i_d_read),
		.i_d_write   (i_d_write),
		.i_d_addr    (i_d_addr),
		.i_d_wdata   (i_d_wdata),
		.o_d_valid   (o_d_valid),
		.o_d_rdata   (o_d_rdata),
		.o_mem_read  (dm_read),
		.o_mem_write (dm_write),
		.o_mem_addr  (dm_addr),
		.o_mem_wline (dm_wline),
		.i_mem_valid (dm_valid),
		.i_mem_rline (dm_rline)
	);

	main_memory #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_main_memory (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_i_read  (im_read),
		.i_i_addr  (im_addr),
		.o_i_valid (im_valid),
		.o_i_rline (im_rline),
		.i_d_read  (dm_read),
		.i_d_write (dm_write),
		.i_d_addr  (dm_addr),
		.i_d_wline (dm_wline),
		.o_d_valid (dm_valid),
		.o_d_rline (dm_rline)
	);

endmodule

// File: tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors = 0;
int other_errors = 0;

task automatic check_word(input string name, input word_t got, input word_t exp);
	if (got !== exp) begin
		$display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		value_errors++;
	end
endtask

task automatic check_cycles(input string name, input int got, input int exp);
	if (got != exp) begin
		$display("CHECK FAILED at %0t ns: %s = %0d cycles, expected %0d cycles",
			$time, name, got, exp);
		value_errors++;
	end
endtask

// one bound per table entry plus the reset
initial begin
	repeat (WATCHDOG_CYCLES) @(posedge clk);
	$display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
	other_errors++;
	report_and_finish();
end

`endif

// File: tb_mem_system.sv
module tb_mem_system;
	timeunit 1ns;
	timeprecision 1ps;
	import mem_pkg::*;

	localparam int MEM_LATENCY = 6;
	localparam int RESET_CYCLES = 2;
	localparam int N_RANDOM = 8;
	localparam int N_ENTRIES = 31 + 2 * N_RANDOM;
	localparam int ENTRY_BOUND = 4 * MEM_LATENCY + 10;
	localparam int WATCHDOG_CYCLES = N_ENTRIES * ENTRY_BOUND + RESET_CYCLES;

	typedef enum logic [1:0] {SIDE_I, SIDE_D, SIDE_BOTH} side_e;
	typedef enum logic {KIND_READ, KIND_WRITE} kind_e;

	// addr2 is the data address of a SIDE_BOTH entry
	typedef struct packed {
		side_e side;
		kind_e kind;
		addr_t addr;
		addr_t addr2;
		word_t wdata;
		logic  i_hit;
		logic  d_hit;
	} entry_t;

	logic clk;
	logic reset_n;
	logic i_fetch;
	addr_t i_fetch_addr;
	logic o_fetch_valid;
	word_t o_fetch_data;
	logic i_d_read;
	logic i_d_write;
	addr_t i_d_addr;
	word_t i_d_wdata;
	logic o_d_valid;
	word_t o_d_rdata;

	entry_t stim [N_ENTRIES];
	int n_built;
	word_t ref_mem [MEM_DEPTH];
	// row 0 of the tag model is the instruction side and row 1 the data side
	logic [TAG_W-1:0] model_tag [2][LINES];
	logic model_valid [2][LINES];

	`include "tb_checks.svh"

	mem_system #(
		.MEM_LATENCY (MEM_LATENCY)
	) UUT (
		.clk           (clk),
		.reset_n       (reset_n),
		.i_fetch       (i_fetch),
		.i_fetch_addr  (i_fetch_addr),
		.o_fetch_valid (o_fetch_valid),
		.o_fetch_data  (o_fetch_data),
		.i_d_read      (i_d_read),
		.i_d_write     (i_d_write),
		.i_d_addr      (i_d_addr),
		.i_d_wdata     (i_d_wdata),
		.o_d_valid     (o_d_valid),
		.o_d_rdata     (o_d_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// index is bits 4..2 and tag is bits 15..5
	// every access allocates
	function automatic logic predict_hit(input int sel, input addr_t a);
		logic [2:0] idx;
		logic hit;
		idx = a[4:2];
		hit = model_valid[sel][idx] && (model_tag[sel][idx] == a[15:5]);
		model_valid[sel][idx] = 1'b1;
		model_tag[sel][idx] = a[15:5];
		return hit;
	endfunction

	task automatic add_entry(input side_e side, input kind_e kind, input addr_t addr,
			input addr_t addr2, input word_t wdata);
		entry_t e;
		e.side = side;
		e.kind = kind;
		e.addr = addr;
		e.addr2 = addr2;
		e.wdata = wdata;
		e.i_hit = 1'b0;
		e.d_hit = 1'b0;
		if (side != SIDE_D)
			e.i_hit = predict_hit(0, addr);
		if (side == SIDE_D)
			e.d_hit = predict_hit(1, addr);
		if (side == SIDE_BOTH)
			e.d_hit = predict_hit(1, addr2);
		if (n_built < N_ENTRIES)
			stim[n_built] = e;
		n_built++;
	endtask

	task automatic build_table();
		addr_t raddr [N_RANDOM];
		n_built = 0;
		for (int s = 0; s < 2; s++) begin
			for (int i = 0; i < LINES; i++) begin
				model_valid[s][i] = 1'b0;
				model_tag[s][i] = '0;
			end
		end
		// every word of the first four instruction lines
		for (int a = 0; a < 16; a++)
			add_entry(SIDE_I, KIND_READ, addr_t'(a), '0, '0);
		add_entry(SIDE_D, KIND_READ, 16'h0014, '0, '0);
		add_entry(SIDE_D, KIND_READ, 16'h0015, '0, '0);
		add_entry(SIDE_D, KIND_READ, 16'h0018, '0, '0);
		add_entry(SIDE_D, KIND_READ, 16'h001b, '0, '0);
		add_entry(SIDE_D, KIND_READ, 16'h001c, '0, '0);
		add_entry(SIDE_D, KIND_READ, 16'h001d, '0, '0);
		// write hit then write miss with each read back
		add_entry(SIDE_D, KIND_WRITE, 16'h0018, '0, 16'h5aa5);
		add_entry(SIDE_D, KIND_READ, 16'h0018, '0, '0);
		add_entry(SIDE_D, KIND_WRITE, 16'h0024, '0, 16'hc33c);
		add_entry(SIDE_D, KIND_READ, 16'h0024, '0, '0);
		// 0x30 shares index 4 with 0x10 and evicts the dirty line
		add_entry(SIDE_D, KIND_WRITE, 16'h0010, '0, 16'hbeef);
		add_entry(SIDE_D, KIND_READ, 16'h0030, '0, '0);
		add_entry(SIDE_D, KIND_READ, 16'h0010, '0, '0);
		add_entry(SIDE_BOTH, KIND_READ, 16'h0005, 16'h0011, '0);
		add_entry(SIDE_BOTH, KIND_READ, 16'h0021, 16'h0040, '0);
		// random writes over the upper half are read back in reverse order
		for (int k = 0; k < N_RANDOM; k++) begin
			raddr[k] = addr_t'(32'h80 + ($urandom % 128));
			add_entry(SIDE_D, KIND_WRITE, raddr[k], '0, word_t'($urandom));
		end
		for (int k = N_RANDOM - 1; k >= 0; k--)
			add_entry(SIDE_D, KIND_READ, raddr[k], '0, '0);
	endtask

	task automatic check_latency(input string name, input logic hit, input int cycles);
		if (hit)
			check_cycles(name, cycles, 1);
		else if (cycles == 1) begin
			$display("%s answered in one cycle at %0t ns although a miss was expected",
				name, $time);
			other_errors++;
		end
	endtask

	task automatic apply_entry(input entry_t e);
		logic want_i;
		logic want_d;
		logic got_i;
		logic got_d;
		addr_t d_addr;
		word_t exp_i;
		word_t exp_d;
		word_t data_i;
		word_t data_d;
		int cyc_i;
		int cyc_d;
		int cycles;
		want_i = (e.side != SIDE_D);
		want_d = (e.side != SIDE_I);
		d_addr = (e.side == SIDE_BOTH) ? e.addr2 : e.addr;
		exp_i = ref_mem[e.addr[7:0]];
		if (e.kind == KIND_WRITE) begin
			exp_d = e.wdata;
			ref_mem[d_addr[7:0]] = e.wdata;
		end else begin
			exp_d = ref_mem[d_addr[7:0]];
		end
		if (want_i) begin
			i_fetch = 1'b1;
			i_fetch_addr = e.addr;
		end
		if (want_d) begin
			i_d_read = (e.kind == KIND_READ);
			i_d_write = (e.kind == KIND_WRITE);
			i_d_addr = d_addr;
			i_d_wdata = e.wdata;
		end
		got_i = !want_i;
		got_d = !want_d;
		cycles = 0;
		cyc_i = 0;
		cyc_d = 0;
		data_i = '0;
		data_d = '0;
		while (!(got_i && got_d) && cycles < ENTRY_BOUND) begin
			@(posedge clk);
			#1;
			i_fetch = 1'b0;
			i_d_read = 1'b0;
			i_d_write = 1'b0;
			cycles++;
			if (!got_i && o_fetch_valid) begin
				got_i = 1'b1;
				cyc_i = cycles;
				data_i = o_fetch_data;
			end
			if (!got_d && o_d_valid) begin
				got_d = 1'b1;
				cyc_d = cycles;
				data_d = o_d_rdata;
			end
		end
		if (!got_i) begin
			$display("fetch of address %h got no valid strobe within %0d cycles",
				e.addr, ENTRY_BOUND);
			other_errors++;
		end else if (want_i) begin
			check_word("o_fetch_data", data_i, exp_i);
			check_latency("o_fetch_valid", e.i_hit, cyc_i);
		end
		if (!got_d) begin
			$display("data access of address %h got no valid strobe within %0d cycles",
				d_addr, ENTRY_BOUND);
			other_errors++;
		end else if (want_d) begin
			check_word("o_d_rdata", data_d, exp_d);
			check_latency("o_d_valid", e.d_hit, cyc_d);
		end
	endtask

	task automatic report_and_finish();
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	initial begin
		void'($urandom(81300));
		reset_n = 1'b0;
		i_fetch = 1'b0;
		i_fetch_addr = '0;
		i_d_read = 1'b0;
		i_d_write = 1'b0;
		i_d_addr = '0;
		i_d_wdata = '0;
		for (int k = 0; k < MEM_DEPTH; k++)
			ref_mem[k] = '0;
		$readmemh("mem_image.hex", ref_mem);
		build_table();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset_n = 1'b1;
		for (int n = 0; n < N_ENTRIES && n < n_built; n++)
			apply_entry(stim[n]);
		report_and_finish();
	end

endmodule

// File: mem_image.hex
// one 16-bit word per line in hex, starting at word address 0
8001
3c12
47a5
9e03
0b64
d2f7
5519
a0c8
6e3d
12f0
c7a1
3b5e
8f42
0d9c
e615
7a38
b2c4
49e7
f01d
2865
93ab
5c70
a8e2
1f46
d73b
04c9
6a51
e98f
37d2
c50e
8b17
f6a3

// File: mem_system.f
+incdir+.
mem_pkg.sv
icache.sv
dcache.sv
main_memory.sv
mem_system.sv
tb_mem_system.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_mem_system -f mem_system.f
./obj_dir/Vtb_mem_system > sim.log
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
